// ==== design/conv_pkg.sv ====
package conv_pkg;

    // Byte width shared by pixels, weights, biases and results
    localparam int DATA_WIDTH = 8;

    // Kernel positions in a 3x3 window
    localparam int TAPS = 9;

    // 27 signed-by-unsigned byte products plus a bias fit here
    localparam int ACC_WIDTH = 22;

    localparam int DEFAULT_IN_CHANNELS    = 3;
    localparam int DEFAULT_OUT_CHANNELS   = 9;
    localparam int DEFAULT_PARALLEL_MULTS = 5;

    // Input FIFO depth, also the sender's starting credits
    localparam int INPUT_CREDITS = 4;

    // Starting credits the receiver grants the DUT
    localparam int OUTPUT_CREDITS = 4;

    localparam int TAP_W     = $clog2(TAPS);
    localparam int PIXEL_MAX = 2 ** DATA_WIDTH - 1;

    // FIFO entry is the weight tag on top of the byte
    localparam int IN_FIFO_W = DATA_WIDTH + 1;

    // Index width for n items, never below one bit
    function automatic int idx_w(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // Counter width that can hold the value n itself
    function automatic int cnt_w(input int n);
        return $clog2(n + 1);
    endfunction

endpackage

// ==== design/kernel_store.sv ====
`timescale 1ns/1ps

module kernel_store #(
    parameter int IN_CHANNELS    = conv_pkg::DEFAULT_IN_CHANNELS,
    parameter int OUT_CHANNELS   = conv_pkg::DEFAULT_OUT_CHANNELS,
    parameter int PARALLEL_MULTS = conv_pkg::DEFAULT_PARALLEL_MULTS
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  wr_en,
    input  logic [conv_pkg::DATA_WIDTH-1:0]       wr_data,
    input  logic [conv_pkg::idx_w(OUT_CHANNELS)-1:0] rd_out_base,
    input  logic [conv_pkg::idx_w(IN_CHANNELS)-1:0]  rd_in_channel,
    input  logic [conv_pkg::TAP_W-1:0]            rd_tap,
    output logic signed [conv_pkg::DATA_WIDTH-1:0] lane_weights [PARALLEL_MULTS],
    output logic signed [conv_pkg::DATA_WIDTH-1:0] biases [OUT_CHANNELS]
);
    import conv_pkg::*;

    // Kernel weights come first, biases after them
    localparam int NUM_WEIGHTS = OUT_CHANNELS * IN_CHANNELS * TAPS;
    localparam int NUM_SLOTS   = NUM_WEIGHTS + OUT_CHANNELS;
    localparam int SLOT_W      = idx_w(NUM_SLOTS);

    logic [SLOT_W-1:0]            slot;
    logic                         slot_is_bias;
    logic signed [DATA_WIDTH-1:0] weight_mem [NUM_WEIGHTS];

    assign slot_is_bias = (int'(slot) >= NUM_WEIGHTS);

    // Slot counter wraps so the next weight byte starts a full reload
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (wr_en) begin
            if (slot == SLOT_W'(NUM_SLOTS - 1)) begin
                slot <= '0;
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

    // Slot order is output channel, then input channel, then tap,
    // which is also the flat layout of weight_mem
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (slot_is_bias) begin
                biases[int'(slot) - NUM_WEIGHTS] <= wr_data;
            end else begin
                weight_mem[slot] <= wr_data;
            end
        end
    end

    always_comb begin
        int oc;
        int addr;
        for (int l = 0; l < PARALLEL_MULTS; l++) begin
            oc   = int'(rd_out_base) + l;
            addr = (oc * IN_CHANNELS + int'(rd_in_channel)) * TAPS + int'(rd_tap);
            // Lanes past the last output channel contribute nothing
            if (oc < OUT_CHANNELS) begin
                lane_weights[l] = weight_mem[addr];
            end else begin
                lane_weights[l] = '0;
            end
        end
    end

endmodule

// ==== design/window_buffer.sv ====
`timescale 1ns/1ps

module window_buffer #(
    parameter int IN_CHANNELS = conv_pkg::DEFAULT_IN_CHANNELS
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wr_en,
    input  logic [conv_pkg::DATA_WIDTH-1:0] wr_data,
    input  logic                            take_window,
    output logic                            wr_ready,
    output logic                            window_full,
    output logic [conv_pkg::DATA_WIDTH-1:0] window [conv_pkg::TAPS*IN_CHANNELS]
);
    import conv_pkg::*;

    localparam int SLOTS = TAPS * IN_CHANNELS;
    localparam int CNT_W = cnt_w(SLOTS);

    logic [CNT_W-1:0] fill_count;
    logic             accept;

    assign window_full = (fill_count == CNT_W'(SLOTS));
    assign wr_ready    = !window_full;
    assign accept      = wr_en && wr_ready;

    // Window is released as soon as the MAC has its own copy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_count <= '0;
        end else if (take_window) begin
            fill_count <= '0;
        end else if (accept) begin
            fill_count <= fill_count + 1'b1;
        end
    end

    // Arrival order is tap major, so slot = tap * IN_CHANNELS + channel
    always_ff @(posedge clk) begin
        if (accept) begin
            window[fill_count] <= wr_data;
        end
    end

endmodule

// ==== design/mac_array.sv ====
`timescale 1ns/1ps

module mac_array #(
    parameter int IN_CHANNELS    = conv_pkg::DEFAULT_IN_CHANNELS,
    parameter int OUT_CHANNELS   = conv_pkg::DEFAULT_OUT_CHANNELS,
    parameter int PARALLEL_MULTS = conv_pkg::DEFAULT_PARALLEL_MULTS
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   window_full,
    input  logic                                   result_empty,
    input  logic [conv_pkg::DATA_WIDTH-1:0]        window [conv_pkg::TAPS*IN_CHANNELS],
    input  logic signed [conv_pkg::DATA_WIDTH-1:0] lane_weights [PARALLEL_MULTS],
    output logic                                   take_window,
    output logic                                   busy,
    output logic [conv_pkg::idx_w(OUT_CHANNELS)-1:0] rd_out_base,
    output logic [conv_pkg::idx_w(IN_CHANNELS)-1:0]  rd_in_channel,
    output logic [conv_pkg::TAP_W-1:0]             rd_tap,
    output logic                                   acc_valid,
    output logic signed [conv_pkg::ACC_WIDTH-1:0]  acc [OUT_CHANNELS]
);
    import conv_pkg::*;

    localparam int OB_W = idx_w(OUT_CHANNELS);
    localparam int IC_W = idx_w(IN_CHANNELS);

    logic                         running;
    logic [DATA_WIDTH-1:0]        window_q [TAPS*IN_CHANNELS];
    logic [DATA_WIDTH-1:0]        pixel;
    logic signed [ACC_WIDTH-1:0]  prod [PARALLEL_MULTS];
    logic                         last_tap;
    logic                         last_channel;
    logic                         last_group;

    // The acc_valid cycle is excluded so the drain sees its own
    // result_empty drop before another window can start
    assign take_window = !running && !acc_valid && window_full && result_empty;
    assign busy        = running || acc_valid;

    assign last_tap     = (rd_tap == TAP_W'(TAPS - 1));
    assign last_channel = (rd_in_channel == IC_W'(IN_CHANNELS - 1));
    assign last_group   = (int'(rd_out_base) + PARALLEL_MULTS >= OUT_CHANNELS);

    assign pixel = window_q[int'(rd_tap) * IN_CHANNELS + int'(rd_in_channel)];

    // Signed weight times zero-extended pixel
    always_comb begin
        for (int l = 0; l < PARALLEL_MULTS; l++) begin
            prod[l] = lane_weights[l] * $signed({1'b0, pixel});
        end
    end

    // Step order is tap, then input channel, then output group
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running       <= 1'b0;
            rd_tap        <= '0;
            rd_in_channel <= '0;
            rd_out_base   <= '0;
            acc_valid     <= 1'b0;
        end else begin
            acc_valid <= 1'b0;
            if (take_window) begin
                running       <= 1'b1;
                rd_tap        <= '0;
                rd_in_channel <= '0;
                rd_out_base   <= '0;
            end else if (running) begin
                if (!last_tap) begin
                    rd_tap <= rd_tap + 1'b1;
                end else begin
                    rd_tap <= '0;
                    if (!last_channel) begin
                        rd_in_channel <= rd_in_channel + 1'b1;
                    end else begin
                        rd_in_channel <= '0;
                        if (last_group) begin
                            running     <= 1'b0;
                            rd_out_base <= '0;
                            acc_valid   <= 1'b1;
                        end else begin
                            rd_out_base <= rd_out_base + OB_W'(PARALLEL_MULTS);
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_window) begin
            window_q <= window;
        end
    end

    // Each lane feeds the channel at rd_out_base plus its lane number
    always_ff @(posedge clk) begin
        if (take_window) begin
            for (int oc = 0; oc < OUT_CHANNELS; oc++) begin
                acc[oc] <= '0;
            end
        end else if (running) begin
            for (int oc = 0; oc < OUT_CHANNELS; oc++) begin
                if (oc >= int'(rd_out_base) && oc < int'(rd_out_base) + PARALLEL_MULTS) begin
                    acc[oc] <= acc[oc] + prod[oc - int'(rd_out_base)];
                end
            end
        end
    end

endmodule

// ==== design/result_drain.sv ====
`timescale 1ns/1ps

module result_drain #(
    parameter int OUT_CHANNELS   = conv_pkg::DEFAULT_OUT_CHANNELS,
    parameter int OUTPUT_CREDITS = conv_pkg::OUTPUT_CREDITS
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   acc_valid,
    input  logic signed [conv_pkg::ACC_WIDTH-1:0]  acc [OUT_CHANNELS],
    input  logic signed [conv_pkg::DATA_WIDTH-1:0] biases [OUT_CHANNELS],
    input  logic                                   out_credit,
    output logic                                   result_empty,
    output logic                                   out_valid,
    output logic [conv_pkg::DATA_WIDTH-1:0]        out_data
);
    import conv_pkg::*;

    localparam int CH_W = idx_w(OUT_CHANNELS);
    localparam int CR_W = cnt_w(OUTPUT_CREDITS);

    logic signed [ACC_WIDTH-1:0] sum [OUT_CHANNELS];
    logic [DATA_WIDTH-1:0]       clamped [OUT_CHANNELS];
    logic [DATA_WIDTH-1:0]       result [OUT_CHANNELS];
    logic                        holding;
    logic [CH_W-1:0]             send_ch;
    logic [CR_W-1:0]             credits;
    logic                        send;

    // Bias add then clamp to the pixel range, which also acts as ReLU
    always_comb begin
        for (int oc = 0; oc < OUT_CHANNELS; oc++) begin
            sum[oc] = acc[oc] + biases[oc];
            if (sum[oc] < 0) begin
                clamped[oc] = '0;
            end else if (sum[oc] > PIXEL_MAX) begin
                clamped[oc] = DATA_WIDTH'(PIXEL_MAX);
            end else begin
                clamped[oc] = sum[oc][DATA_WIDTH-1:0];
            end
        end
    end

    assign send         = holding && (credits != '0);
    assign out_valid    = send;
    assign out_data     = result[send_ch];
    assign result_empty = !holding;

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            result <= clamped;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            holding <= 1'b0;
            send_ch <= '0;
            credits <= CR_W'(OUTPUT_CREDITS);
        end else begin
            credits <= credits + CR_W'(out_credit) - CR_W'(send);
            if (acc_valid) begin
                holding <= 1'b1;
                send_ch <= '0;
            end else if (send) begin
                if (send_ch == CH_W'(OUT_CHANNELS - 1)) begin
                    holding <= 1'b0;
                    send_ch <= '0;
                end else begin
                    send_ch <= send_ch + 1'b1;
                end
            end
        end
    end

endmodule

// ==== design/conv_engine_top.sv ====
`timescale 1ns/1ps

module conv_engine_top #(
    parameter int IN_CHANNELS    = conv_pkg::DEFAULT_IN_CHANNELS,
    parameter int OUT_CHANNELS   = conv_pkg::DEFAULT_OUT_CHANNELS,
    parameter int PARALLEL_MULTS = conv_pkg::DEFAULT_PARALLEL_MULTS,
    parameter int OUTPUT_CREDITS = conv_pkg::OUTPUT_CREDITS
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic [conv_pkg::DATA_WIDTH-1:0] in_data,
    input  logic                          in_is_weight,
    input  logic                          out_credit,
    output logic                          in_credit,
    output logic                          out_valid,
    output logic [conv_pkg::DATA_WIDTH-1:0] out_data
);
    import conv_pkg::*;

    localparam int PTR_W = idx_w(INPUT_CREDITS);
    localparam int CNT_W = cnt_w(INPUT_CREDITS);

    logic [IN_FIFO_W-1:0] fifo_mem [INPUT_CREDITS];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     fifo_count;
    logic                 fifo_empty;
    logic                 head_is_weight;
    logic [DATA_WIDTH-1:0] head_data;
    logic                 pop;
    logic                 ks_wr_en;
    logic                 wb_wr_en;
    logic                 wb_ready;

    logic                  window_full;
    logic                  take_window;
    logic [DATA_WIDTH-1:0] window [TAPS*IN_CHANNELS];
    logic                  mac_busy;
    logic [idx_w(OUT_CHANNELS)-1:0] rd_out_base;
    logic [idx_w(IN_CHANNELS)-1:0]  rd_in_channel;
    logic [TAP_W-1:0]               rd_tap;
    logic signed [DATA_WIDTH-1:0]   lane_weights [PARALLEL_MULTS];
    logic signed [DATA_WIDTH-1:0]   biases [OUT_CHANNELS];
    logic                           acc_valid;
    logic signed [ACC_WIDTH-1:0]    acc [OUT_CHANNELS];
    logic                           result_empty;

    assign fifo_empty     = (fifo_count == '0);
    assign head_is_weight = fifo_mem[rd_ptr][DATA_WIDTH];
    assign head_data      = fifo_mem[rd_ptr][DATA_WIDTH-1:0];

    // Weights wait while a window computes, pixels wait for buffer room
    assign pop      = !fifo_empty && (head_is_weight ? !mac_busy : wb_ready);
    assign ks_wr_en = pop && head_is_weight;
    assign wb_wr_en = pop && !head_is_weight;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            fifo_mem[wr_ptr] <= {in_is_weight, in_data};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
            in_credit  <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(INPUT_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(INPUT_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fifo_count <= fifo_count + CNT_W'(in_valid) - CNT_W'(pop);
            // One credit back per popped byte
            in_credit  <= pop;
        end
    end

    kernel_store #(
        .IN_CHANNELS   (IN_CHANNELS),
        .OUT_CHANNELS  (OUT_CHANNELS),
        .PARALLEL_MULTS(PARALLEL_MULTS)
    ) u_kernel_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (ks_wr_en),
        .wr_data      (head_data),
        .rd_out_base  (rd_out_base),
        .rd_in_channel(rd_in_channel),
        .rd_tap       (rd_tap),
        .lane_weights (lane_weights),
        .biases       (biases)
    );

    window_buffer #(
        .IN_CHANNELS(IN_CHANNELS)
    ) u_window_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wb_wr_en),
        .wr_data    (head_data),
        .take_window(take_window),
        .wr_ready   (wb_ready),
        .window_full(window_full),
        .window     (window)
    );

    mac_array #(
        .IN_CHANNELS   (IN_CHANNELS),
        .OUT_CHANNELS  (OUT_CHANNELS),
        .PARALLEL_MULTS(PARALLEL_MULTS)
    ) u_mac_array (
        .clk          (clk),
        .rst_n        (rst_n),
        .window_full  (window_full),
        .result_empty (result_empty),
        .window       (window),
        .lane_weights (lane_weights),
        .take_window  (take_window),
        .busy         (mac_busy),
        .rd_out_base  (rd_out_base),
        .rd_in_channel(rd_in_channel),
        .rd_tap       (rd_tap),
        .acc_valid    (acc_valid),
        .acc          (acc)
    );

    result_drain #(
        .OUT_CHANNELS  (OUT_CHANNELS),
        .OUTPUT_CREDITS(OUTPUT_CREDITS)
    ) u_result_drain (
        .clk         (clk),
        .rst_n       (rst_n),
        .acc_valid   (acc_valid),
        .acc         (acc),
        .biases      (biases),
        .out_credit  (out_credit),
        .result_empty(result_empty),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

endmodule

// ==== sim/conv_model.svh ====
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

int mismatch_errors = 0;
int other_errors = 0;

// Flat kernel layout: output channel, then input channel, then tap
int model_weight [OUT_CH*IN_CH*TAPS];
int model_bias [OUT_CH];

// Expected result bytes in the order they leave the DUT
logic [DATA_WIDTH-1:0] exp_q [$];
int expected_total = 0;

function automatic int clamp_byte(input int value);
    if (value < 0) begin
        return 0;
    end else if (value > 255) begin
        return 255;
    end
    return value;
endfunction

// One output channel per byte: bias plus signed weight times unsigned pixel
task automatic queue_expected();
    int sum;
    int w_idx;
    int p_idx;
    for (int oc = 0; oc < OUT_CH; oc++) begin
        sum = model_bias[oc];
        for (int ic = 0; ic < IN_CH; ic++) begin
            for (int tap = 0; tap < TAPS; tap++) begin
                w_idx = (oc * IN_CH + ic) * TAPS + tap;
                // Pixels arrive tap major
                p_idx = tap * IN_CH + ic;
                sum = sum + model_weight[w_idx] * window_px[p_idx];
            end
        end
        exp_q.push_back(DATA_WIDTH'(clamp_byte(sum)));
        expected_total++;
    end
endtask

task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
        mismatch_errors++;
        $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
    end
endtask

task automatic flag_error(input string what);
    other_errors++;
    $display("ERROR: %s (time %0t)", what, $time);
endtask

`endif

// ==== sim/tb_conv_engine.sv ====
`timescale 1ns/1ps

module tb_conv_engine;
    import conv_pkg::*;

    localparam int IN_CH  = DEFAULT_IN_CHANNELS;
    localparam int OUT_CH = DEFAULT_OUT_CHANNELS;
    // About 40 windows of about 100 cycles each plus room for credit stalls
    localparam int TIMEOUT_CYCLES = 20000;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  in_valid;
    logic [DATA_WIDTH-1:0] in_data;
    logic                  in_is_weight;
    logic                  out_credit;
    logic                  in_credit;
    logic                  out_valid;
    logic [DATA_WIDTH-1:0] out_data;

    logic [31:0] lfsr_state = 32'd94043;
    int    window_px [TAPS*IN_CH];
    int    sender_credits = INPUT_CREDITS;
    int    dut_credits = OUTPUT_CREDITS;
    int    pending_returns = 0;
    int    bytes_sent = 0;
    int    credits_seen = 0;
    int    out_received = 0;
    int    cycle_count = 0;
    int    stall_left = 0;
    bit    stall_enable = 1'b0;
    string test_name = "reset";

    `include "conv_model.svh"

    conv_engine_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_is_weight(in_is_weight),
        .out_credit  (out_credit),
        .in_credit   (in_credit),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

    always #4 clk = ~clk;

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic int rand_bits(input int n);
        int   value;
        logic fb;
        value = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = (value << 1) | int'(fb);
        end
        return value;
    endfunction

    // Called 1 ns after a rising edge and returns at the same phase
    task automatic send_byte(input logic [DATA_WIDTH-1:0] data, input logic is_weight);
        if (rand_bits(3) == 0) begin
            in_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        while (sender_credits == 0) begin
            in_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        in_valid     = 1'b1;
        in_data      = data;
        in_is_weight = is_weight;
        sender_credits--;
        bytes_sent++;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // Mode 0 gives small weights and mode 1 large ones that saturate
    task automatic load_weights(input int mode);
        int w;
        int b;
        for (int oc = 0; oc < OUT_CH; oc++) begin
            for (int ic = 0; ic < IN_CH; ic++) begin
                for (int tap = 0; tap < TAPS; tap++) begin
                    if (mode == 0) begin
                        w = rand_bits(3) - 4;
                    end else begin
                        w = 100 + rand_bits(4);
                        if (oc % 3 == 1 || (oc % 3 == 2 && rand_bits(1) == 1)) begin
                            w = -w;
                        end
                    end
                    model_weight[(oc * IN_CH + ic) * TAPS + tap] = w;
                    send_byte(DATA_WIDTH'(w), 1'b1);
                end
            end
        end
        for (int oc = 0; oc < OUT_CH; oc++) begin
            if (mode == 0) begin
                b = rand_bits(8) - 128;
            end else begin
                b = (oc % 3 == 1) ? -128 : 127;
            end
            model_bias[oc] = b;
            send_byte(DATA_WIDTH'(b), 1'b1);
        end
    endtask

    task automatic send_window(input int pix_bits);
        for (int i = 0; i < TAPS * IN_CH; i++) begin
            window_px[i] = rand_bits(pix_bits);
        end
        queue_expected();
        for (int i = 0; i < TAPS * IN_CH; i++) begin
            send_byte(DATA_WIDTH'(window_px[i]), 1'b0);
        end
    endtask

    // All results out and every output credit back
    task automatic wait_drain();
        while (exp_q.size() != 0 || pending_returns != 0 ||
               dut_credits != OUTPUT_CREDITS) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Bus monitor at mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (in_credit) begin
                credits_seen++;
                sender_credits++;
                if (sender_credits > INPUT_CREDITS) begin
                    flag_error("input credit returned beyond the starting credit count");
                end
            end
            if (out_valid) begin
                if (dut_credits <= 0) begin
                    flag_error("output byte sent without credit");
                end
                dut_credits--;
                pending_returns++;
                if (exp_q.size() == 0) begin
                    flag_error("output byte arrived with no result expected");
                end else begin
                    check_value($sformatf("%s byte %0d", test_name, out_received),
                                exp_q.pop_front(), out_data);
                end
                out_received++;
            end
            if (out_credit) begin
                dut_credits++;
                if (dut_credits > OUTPUT_CREDITS) begin
                    flag_error("output credits returned beyond the starting credit count");
                end
            end
        end
    end

    // Receiver hands credits back with random stalls when enabled
    always @(posedge clk) begin
        #2;
        out_credit = 1'b0;
        if (stall_left > 0) begin
            stall_left--;
        end else if (stall_enable && rand_bits(2) == 0) begin
            stall_left = rand_bits(4);
        end else if (pending_returns > 0) begin
            out_credit = 1'b1;
            pending_returns--;
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        in_is_weight = 1'b0;
        out_credit   = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("reset in_credit", 0, in_credit);
        check_value("reset out_valid", 0, out_valid);

        test_name = "single window";
        load_weights(0);
        send_window(6);
        wait_drain();

        test_name = "back to back";
        repeat (30) send_window(6);
        wait_drain();

        test_name = "clamp";
        load_weights(1);
        repeat (3) send_window(8);
        wait_drain();

        test_name = "reload";
        load_weights(0);
        repeat (4) send_window(6);
        wait_drain();

        test_name = "credit stall";
        stall_enable = 1'b1;
        repeat (8) send_window(6);
        wait_drain();
        stall_enable = 1'b0;

        repeat (4) @(posedge clk);
        #1;
        check_value("final sender credits", INPUT_CREDITS, sender_credits);
        check_value("input credits returned", bytes_sent, credits_seen);
        check_value("result bytes received", expected_total, out_received);
        check_value("idle in_credit", 0, in_credit);
        check_value("idle out_valid", 0, out_valid);

        $display("Errors: %0d value mismatches, %0d protocol errors",
                 mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+sim
design/conv_pkg.sv
design/kernel_store.sv
design/window_buffer.sv
design/mac_array.sv
design/result_drain.sv
design/conv_engine_top.sv
sim/tb_conv_engine.sv
